//--- dv/lsu_mem_assert.sv
// handshake stability and reset assertions for the load/store top
// bound into lsu_mem_top

module lsu_mem_assert import lsu_pkg::*; (
  input logic              clk,
  input logic              arst_n,
  input logic              cmd_valid,
  input logic              cmd_ready,
  input op_e               cmd_op,
  input logic [ADDR_W-1:0] cmd_addr,
  input logic [DATA_W-1:0] cmd_wdata,
  input logic              rsp_valid,
  input logic              rsp_ready,
  input logic [DATA_W-1:0] rsp_data
);

  int n_fail = 0;  // failure count

  // command fields frozen while waiting for cmd_ready
  a_cmd_hold: assert property (@(posedge clk) disable iff (!arst_n)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable({cmd_op, cmd_addr, cmd_wdata}))
    else begin
      $error("command dropped or changed while cmd_ready was low");
      n_fail++;
    end

  a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))  // held response
    else begin
      $error("response dropped or changed while rsp_ready was low");
      n_fail++;
    end

  a_rst_quiet: assert property (@(posedge clk) !arst_n |-> !rsp_valid)
    else begin
      $error("rsp_valid high during reset");
      n_fail++;
    end

endmodule : lsu_mem_assert

bind lsu_mem_top lsu_mem_assert u_assert (.*);

//--- dv/lsu_mem_tb.sv
// testbench for the load/store path
// LFSR stimulus, byte reference model, in-order response check

module lsu_mem_tb import lsu_pkg::*; ();

  localparam int N_RAND  = 200;                          // random mix length
  localparam int N_CMDS  = 512 + 24 + 36 + 12 + N_RAND;  // all tests
  localparam int T_LIMIT = N_CMDS * 12 + 200;            // cycles

  logic              clk, arst_n, cmd_valid, cmd_ready, rsp_valid, rsp_ready;
  op_e               cmd_op;
  logic [ADDR_W-1:0] cmd_addr;
  logic [DATA_W-1:0] cmd_wdata, rsp_data;

  logic [7:0]        ref_mem [MEM_BYTES];  // byte model
  logic [DATA_W-1:0] exp_q [$];            // expected load data, command order
  logic [15:0]       lfsr = 16'd36;
  logic              stall_en = 1'b0;      // random rsp_ready when set
  int n_chk, n_err, n_loads, n_rsp, cycles, chk0, err0, ld0, rsp0;

  lsu_mem_top uut (.*);

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // LFSR and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // taps 16,14,13,11
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};  // one step per bit
    end
  endtask

  function automatic void store_ref(input op_e op, input logic [ADDR_W-1:0] a,
                                    input logic [DATA_W-1:0] d);
    int n;
    n = (op == OP_SW) ? 4 : (op == OP_SH) ? 2 : 1;
    a = a & ~(ADDR_W'(n - 1));  // align down to size
    for (int i = 0; i < n; i++)
      ref_mem[a + i] = d[8*i +: 8];
  endfunction

  function automatic logic [DATA_W-1:0] load_ref(input op_e op, input logic [ADDR_W-1:0] a);
    if (op == OP_LW) a[1:0] = 2'b00;
    if (op == OP_LH || op == OP_LHU) a[0] = 1'b0;
    case (op)
      OP_LB:   return {{24{ref_mem[a][7]}}, ref_mem[a]};
      OP_LBU:  return {24'h0, ref_mem[a]};
      OP_LH:   return {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
      OP_LHU:  return {16'h0, ref_mem[a+1], ref_mem[a]};
      default: return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // monitors, compare, watchdog
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin  // command port, model follows taken commands
    if (arst_n && cmd_valid && cmd_ready) begin
      if (cmd_op inside {OP_SB, OP_SH, OP_SW}) store_ref(cmd_op, cmd_addr, cmd_wdata);
      else begin
        exp_q.push_back(load_ref(cmd_op, cmd_addr));
        n_loads++;
      end
    end
  end

  always @(posedge clk) begin
    logic [DATA_W-1:0] exp_data;
    if (arst_n && rsp_valid && rsp_ready) begin
      n_rsp++;
      if (exp_q.size() == 0) begin
        $display("error t=%0t unexpected response with no load outstanding", $time);
        n_err++;
      end else begin
        exp_data = exp_q.pop_front();
        n_chk++;
        assert (rsp_data === exp_data) else begin
          $display("error t=%0t rsp_data exp=%h got=%h", $time, exp_data, rsp_data);
          n_err++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > T_LIMIT) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic tick();
    logic [31:0] r;
    @(posedge clk);
    if (stall_en) begin
      take_bits(1, r);
      rsp_ready <= r[0];  // low about half the cycles
    end else begin
      rsp_ready <= 1'b1;
    end
  endtask

  task automatic send_cmd(input op_e op, input logic [ADDR_W-1:0] a,
                          input logic [DATA_W-1:0] d);
    cmd_valid <= 1'b1;
    cmd_op    <= op;
    cmd_addr  <= a;
    cmd_wdata <= d;
    tick();
    while (!cmd_ready) tick();  // held until taken
    cmd_valid <= 1'b0;
  endtask

  task automatic end_test(input string name);
    stall_en = 1'b0;
    while (n_rsp < n_loads) tick();
    repeat (8) tick();  // catch stray responses
    n_chk++;
    assert (n_rsp - rsp0 == n_loads - ld0) else begin
      $display("%0d responses came back for %0d loads", n_rsp - rsp0, n_loads - ld0);
      n_err++;
    end
    $display("test %s: %0d checks, %0d errors", name, n_chk - chk0, n_err - err0);
    {chk0, err0, ld0, rsp0} = {n_chk, n_err, n_loads, n_rsp};
  endtask

  initial begin
    logic [31:0] r, a, d;
    clk       = 1'b0;
    arst_n    <= 1'b0;
    cmd_valid = 1'b0;
    cmd_op    = OP_LB;
    cmd_addr  = '0;
    cmd_wdata = '0;
    rsp_ready = 1'b1;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < 10; i++) begin  // idle after reset
      tick();
      n_chk++;
      assert (cmd_ready === 1'b1 && rsp_valid === 1'b0) else begin
        $display("error t=%0t cmd_ready,rsp_valid exp=1,0 got=%b,%b",
                 $time, cmd_ready, rsp_valid);
        n_err++;
      end
    end
    end_test("reset state");
    for (int i = 0; i < MEM_BYTES / 4; i++) begin  // fills the whole memory
      take_bits(32, d);
      send_cmd(OP_SW, ADDR_W'(4 * i), d);
    end
    for (int i = 0; i < MEM_BYTES / 4; i++)
      send_cmd(OP_LW, ADDR_W'(4 * i), '0);
    end_test("word store and load");
    for (int k = 0; k < 8; k++) begin  // sb at lanes 0..3, then sh at 0 and 2
      take_bits(32, d);
      send_cmd(OP_SW, ADDR_W'(256 + 4*k), d);
      take_bits(16, d);
      if (k < 4) send_cmd(OP_SB, ADDR_W'(256 + 4*k + k), d);
      else send_cmd(OP_SH, ADDR_W'(256 + 4*k + 2*(k % 2)), d);
      send_cmd(OP_LW, ADDR_W'(256 + 4*k), '0);
    end
    end_test("lane merge");
    for (int k = 0; k < 8; k++) begin  // offset k/2, top bit k[0]
      take_bits(7, d);
      send_cmd(OP_SB, ADDR_W'(512 + k/2), {24'h0, k[0], d[6:0]});
      send_cmd(OP_LB, ADDR_W'(512 + k/2), '0);
      send_cmd(OP_LBU, ADDR_W'(512 + k/2), '0);
    end
    for (int k = 0; k < 4; k++) begin  // offset 0 or 2
      take_bits(15, d);
      send_cmd(OP_SH, ADDR_W'(520 + 2*(k/2)), {16'h0, k[0], d[14:0]});
      send_cmd(OP_LH, ADDR_W'(520 + 2*(k/2)), '0);
      send_cmd(OP_LHU, ADDR_W'(520 + 2*(k/2)), '0);
    end
    end_test("sign and zero extend");
    for (int k = 1; k < 4; k++) begin  // low address bits 1..3
      take_bits(32, d);
      send_cmd(OP_SW, ADDR_W'(768 + 5*k), d);
      send_cmd(OP_LW, ADDR_W'(768 + 5*k), '0);
      send_cmd(OP_SH, ADDR_W'(768 + 5*k), ~d);
      send_cmd(OP_LH, ADDR_W'(768 + 5*k), '0);
    end
    end_test("misaligned address");
    stall_en = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      take_bits(3, r);
      take_bits(ADDR_W, a);
      take_bits(32, d);
      send_cmd(op_e'(r[2:0]), a[ADDR_W-1:0], d);
    end
    end_test("random mix with stalls");
    n_err += uut.u_assert.n_fail;
    $display("checks %0d, errors %0d, loads %0d, responses %0d, assertion failures %0d",
             n_chk, n_err, n_loads, n_rsp, uut.u_assert.n_fail);
    if (n_err == 0) $display("RESULT: PASS");
    else $display("RESULT: FAIL");
    $finish;
  end

endmodule : lsu_mem_tb

//--- sim.f
verilog/lsu_pkg.sv
verilog/lsu_req.sv
verilog/req_fifo.sv
verilog/mem_ram.sv
verilog/ld_align.sv
verilog/lsu_mem_top.sv
dv/lsu_mem_assert.sv
dv/lsu_mem_tb.sv

//--- verilog/ld_align.sv
// load aligner
// byte/half extraction, sign or zero extension, output register

module ld_align import lsu_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  // read word from memory
  input  logic              rd_valid,
  output logic              rd_ready,
  input  logic [DATA_W-1:0] rd_data,
  input  op_e               rd_op,
  input  logic [1:0]        rd_off,
  // load response
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output logic [DATA_W-1:0] rsp_data
);

  logic [DATA_W-1:0] shifted;  // addressed lane at bit 0
  logic [DATA_W-1:0] n_data;

  assign shifted = rd_data >> {rd_off, 3'b000};

  always_comb begin
    case (rd_op)
      OP_LB:   n_data = {{(DATA_W-8){shifted[7]}}, shifted[7:0]};
      OP_LH:   n_data = {{(DATA_W-16){shifted[15]}}, shifted[15:0]};
      OP_LBU:  n_data = {{(DATA_W-8){1'b0}}, shifted[7:0]};
      OP_LHU:  n_data = {{(DATA_W-16){1'b0}}, shifted[15:0]};
      default: n_data = rd_data;  // lw, stores never get here
    endcase
  end

  // output stage
  assign rd_ready = !rsp_valid || rsp_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
    end else if (rd_ready) begin
      rsp_valid <= rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid && rd_ready) rsp_data <= n_data;
  end

endmodule : ld_align

//--- verilog/lsu_mem_top.sv
// load/store path top level
// formatter -> request FIFO -> memory -> load aligner

module lsu_mem_top import lsu_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  // command port
  input  logic              cmd_valid,
  output logic              cmd_ready,
  input  op_e               cmd_op,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic [DATA_W-1:0] cmd_wdata,
  // load response port
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output logic [DATA_W-1:0] rsp_data
);

  ////////////////////////////////////////////////////////////////////////////
  // internal buses
  ////////////////////////////////////////////////////////////////////////////

  // formatter to FIFO
  logic               rq_valid, rq_ready, rq_wen;
  logic [SEL_W-1:0]   rq_sel;
  logic [WORD_AW-1:0] rq_word;
  logic [DATA_W-1:0]  rq_wdata;
  op_e                rq_op;
  logic [1:0]         rq_off;

  // FIFO head to memory
  logic               hd_valid, hd_ready, hd_wen;
  logic [SEL_W-1:0]   hd_sel;
  logic [WORD_AW-1:0] hd_word;
  logic [DATA_W-1:0]  hd_wdata;
  op_e                hd_op;
  logic [1:0]         hd_off;

  // memory to aligner
  logic               rd_valid, rd_ready;
  logic [DATA_W-1:0]  rd_data;
  op_e                rd_op;
  logic [1:0]         rd_off;

  ////////////////////////////////////////////////////////////////////////////
  // stages
  ////////////////////////////////////////////////////////////////////////////

  lsu_req u_req (.*);

  req_fifo u_fifo (.*);

  mem_ram u_mem (.*);

  ld_align u_align (.*);

endmodule : lsu_mem_top

//--- verilog/lsu_pkg.sv
// shared definitions for the load/store path
// opcode enum, bus widths, memory size, request FIFO depth

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////////////////////////////////////////

  // RISC-V style loads and stores
  typedef enum logic [2:0] {
    OP_LB  = 3'd0,  // load byte, sign extended
    OP_LH  = 3'd1,  // load half, sign extended
    OP_LW  = 3'd2,  // load word
    OP_LBU = 3'd3,  // load byte, zero extended
    OP_LHU = 3'd4,  // load half, zero extended
    OP_SB  = 3'd5,  // store byte
    OP_SH  = 3'd6,  // store half
    OP_SW  = 3'd7   // store word
  } op_e;

  ////////////////////////////////////////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned DATA_W    = 32;                // data bus
  localparam int unsigned SEL_W     = DATA_W / 8;        // byte lanes
  localparam int unsigned MEM_BYTES = 1024;              // 1kB data memory
  localparam int unsigned ADDR_W    = $clog2(MEM_BYTES); // byte address
  localparam int unsigned WORD_AW   = ADDR_W - 2;        // word address

  // request buffer
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned FIFO_AW    = $clog2(FIFO_DEPTH);

endpackage : lsu_pkg

//--- verilog/lsu_req.sv
// request formatter, command to byte-select bus request
// opcode decode, lane select, store data replication, output register

module lsu_req import lsu_pkg::*; (
  input  logic               clk,
  input  logic               arst_n,
  // command side
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  op_e                cmd_op,
  input  logic [ADDR_W-1:0]  cmd_addr,
  input  logic [DATA_W-1:0]  cmd_wdata,
  // request bus
  output logic               rq_valid,
  input  logic               rq_ready,
  output logic               rq_wen,
  output logic [SEL_W-1:0]   rq_sel,
  output logic [WORD_AW-1:0] rq_word,
  output logic [DATA_W-1:0]  rq_wdata,
  output op_e                rq_op,
  output logic [1:0]         rq_off
);

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  logic              n_wen;    // store
  logic              is_half;  // 2 byte access
  logic              is_word;  // 4 byte access
  logic [1:0]        off_al;   // offset aligned down to size
  logic [SEL_W-1:0]  n_sel;
  logic [DATA_W-1:0] n_wdata;

  always_comb begin
    n_wen   = 1'b0;
    is_half = 1'b0;
    is_word = 1'b0;
    case (cmd_op)
      OP_SB: n_wen = 1'b1;
      OP_SH: begin
        n_wen   = 1'b1;
        is_half = 1'b1;
      end
      OP_SW: begin
        n_wen   = 1'b1;
        is_word = 1'b1;
      end
      OP_LH, OP_LHU: is_half = 1'b1;
      OP_LW:         is_word = 1'b1;
      default: ;  // byte loads keep the defaults
    endcase
  end

  // misaligned low bits are dropped, no trap
  assign off_al = is_word ? 2'b00 : (is_half ? {cmd_addr[1], 1'b0} : cmd_addr[1:0]);

  assign n_sel = is_word ? '1
               : is_half ? SEL_W'(3) << off_al
               :           SEL_W'(1) << off_al;

  // low bytes repeated across lanes, sel picks the live ones
  assign n_wdata = is_word ? cmd_wdata
                 : is_half ? {2{cmd_wdata[15:0]}}
                 :           {4{cmd_wdata[7:0]}};

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  assign cmd_ready = !rq_valid || rq_ready;  // empty or draining

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rq_valid <= 1'b0;
    end else if (cmd_ready) begin
      rq_valid <= cmd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      rq_wen   <= n_wen;
      rq_sel   <= n_sel;
      rq_word  <= cmd_addr[ADDR_W-1:2];  // drop byte offset
      rq_wdata <= n_wdata;
      rq_op    <= cmd_op;
      rq_off   <= off_al;                // for the load aligner
    end
  end

endmodule : lsu_req

//--- verilog/mem_ram.sv
// byte-array data memory with byte-lane writes
// one request per cycle, registered read response with handshake

module mem_ram import lsu_pkg::*; (
  input  logic               clk,
  input  logic               arst_n,
  // request from FIFO head
  input  logic               hd_valid,
  output logic               hd_ready,
  input  logic               hd_wen,
  input  logic [SEL_W-1:0]   hd_sel,
  input  logic [WORD_AW-1:0] hd_word,
  input  logic [DATA_W-1:0]  hd_wdata,
  input  op_e                hd_op,
  input  logic [1:0]         hd_off,
  // read response
  output logic               rd_valid,
  input  logic               rd_ready,
  output logic [DATA_W-1:0]  rd_data,
  output op_e                rd_op,
  output logic [1:0]         rd_off
);

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  logic [7:0] mem [MEM_BYTES];  // contents undefined until written

  logic do_wr;  // store popped this cycle
  logic do_rd;  // load popped this cycle

  // stores never stall, loads wait for room in the read register
  assign hd_ready = hd_wen || !rd_valid || rd_ready;
  assign do_wr    = hd_valid && hd_ready && hd_wen;
  assign do_rd    = hd_valid && hd_ready && !hd_wen;

  ////////////////////////////////////////////////////////////////////////////
  // write and read access
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_wr) begin
      for (int i = 0; i < SEL_W; i++) begin
        if (hd_sel[i]) mem[{hd_word, 2'(i)}] <= hd_wdata[8*i +: 8];  // lane i
      end
    end
  end

  // full word, the aligner picks the bytes
  always_ff @(posedge clk) begin
    if (do_rd) begin
      for (int i = 0; i < SEL_W; i++) begin
        rd_data[8*i +: 8] <= mem[{hd_word, 2'(i)}];
      end
      rd_op  <= hd_op;
      rd_off <= hd_off;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response valid
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid <= 1'b0;
    end else if (do_rd) begin
      rd_valid <= 1'b1;        // new load replaces drained one
    end else if (rd_ready) begin
      rd_valid <= 1'b0;
    end
  end

endmodule : mem_ram

//--- verilog/req_fifo.sv
// request FIFO between formatter and memory
// circular buffer, pointers and occupancy count

module req_fifo import lsu_pkg::*; (
  input  logic               clk,
  input  logic               arst_n,
  // write side
  input  logic               rq_valid,
  output logic               rq_ready,
  input  logic               rq_wen,
  input  logic [SEL_W-1:0]   rq_sel,
  input  logic [WORD_AW-1:0] rq_word,
  input  logic [DATA_W-1:0]  rq_wdata,
  input  op_e                rq_op,
  input  logic [1:0]         rq_off,
  // head of queue
  output logic               hd_valid,
  input  logic               hd_ready,
  output logic               hd_wen,
  output logic [SEL_W-1:0]   hd_sel,
  output logic [WORD_AW-1:0] hd_word,
  output logic [DATA_W-1:0]  hd_wdata,
  output op_e                hd_op,
  output logic [1:0]         hd_off
);

  // entry storage, one array per field
  logic               e_wen   [FIFO_DEPTH];
  logic [SEL_W-1:0]   e_sel   [FIFO_DEPTH];
  logic [WORD_AW-1:0] e_word  [FIFO_DEPTH];
  logic [DATA_W-1:0]  e_wdata [FIFO_DEPTH];
  op_e                e_op    [FIFO_DEPTH];
  logic [1:0]         e_off   [FIFO_DEPTH];

  logic [FIFO_AW-1:0] wr_ptr, rd_ptr;  // wrap at depth
  logic [FIFO_AW:0]   count;           // 0..FIFO_DEPTH
  logic               full, push, pop;

  assign full     = (count == (FIFO_AW+1)'(FIFO_DEPTH));
  assign hd_valid = (count != '0);
  assign rq_ready = !full || hd_ready;  // full queue still takes one on pop
  assign push     = rq_valid && rq_ready;
  assign pop      = hd_valid && hd_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      count <= count + (FIFO_AW+1)'(push) - (FIFO_AW+1)'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      e_wen[wr_ptr]   <= rq_wen;
      e_sel[wr_ptr]   <= rq_sel;
      e_word[wr_ptr]  <= rq_word;
      e_wdata[wr_ptr] <= rq_wdata;
      e_op[wr_ptr]    <= rq_op;
      e_off[wr_ptr]   <= rq_off;
    end
  end

  // head read straight from storage
  assign hd_wen   = e_wen[rd_ptr];
  assign hd_sel   = e_sel[rd_ptr];
  assign hd_word  = e_word[rd_ptr];
  assign hd_wdata = e_wdata[rd_ptr];
  assign hd_op    = e_op[rd_ptr];
  assign hd_off   = e_off[rd_ptr];

endmodule : req_fifo
